//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f vlog.f --top-module mips_tb \
  -Mdir obj_dir -o mips_sim

./obj_dir/mips_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  exit 1
fi
exit 0

//--- source/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import mips_pkg::*; (
  input  logic    clk,
  input  logic    i_rst_n,
  input  id_ex_t  i_id_ex,
  output ex_mem_t o_ex_mem
);

  alu_ctl_e    alu_ctl;
  logic        funct_ok;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_result;
  logic [4:0]  dest;
  ex_mem_t     ex_mem_d;

  // ALU control
  always_comb begin
    alu_ctl  = ALU_ADD;
    funct_ok = 1'b1;
    if (i_id_ex.ctrl.alu_op == ALUOP_FUNCT) begin
      case (i_id_ex.funct)
        FN_ADD:  alu_ctl = ALU_ADD;
        FN_SUB:  alu_ctl = ALU_SUB;
        FN_AND:  alu_ctl = ALU_AND;
        FN_OR:   alu_ctl = ALU_OR;
        FN_SLT:  alu_ctl = ALU_SLT;
        default: funct_ok = 1'b0; // Also catches the all-zero word
      endcase
    end
  end

  assign op_a = i_id_ex.read_data_1;
  assign op_b = i_id_ex.ctrl.alu_src ? i_id_ex.sign_extended_imm : i_id_ex.read_data_2;

  always_comb begin
    case (alu_ctl)
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  assign dest = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;

  always_comb begin
    ex_mem_d.ctrl           = i_id_ex.ctrl;
    // Drop writes for bad funct and for r0
    ex_mem_d.ctrl.reg_write = i_id_ex.ctrl.reg_write && funct_ok && (dest != 5'd0);
    ex_mem_d.alu_result     = alu_result;
    ex_mem_d.write_data     = i_id_ex.read_data_2;
    ex_mem_d.write_register = dest;
  end

  // EX/MEM latch
  always_ff @(posedge clk) begin
    o_ex_mem <= ex_mem_d;
    if (!i_rst_n) begin
      o_ex_mem.ctrl <= '0;
    end
  end

endmodule

//--- source/id_stage.sv
`timescale 1ns/1ps

module id_stage import mips_pkg::*; (
  input  logic   clk,
  input  logic   i_rst_n,
  input  if_id_t i_if_id,
  input  wb_t    i_wb,
  output id_ex_t o_id_ex
);

  logic [31:0] regs [32];
  ctrl_t       ctrl;
  id_ex_t      id_ex_d;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [31:0] read_data_1;
  logic [31:0] read_data_2;

  // Register read with write-through from the write-back bus
  function automatic logic [31:0] read_reg(
    input logic [4:0]  addr,
    input logic [31:0] stored,
    input wb_t         wb
  );
    if (addr == 5'd0) begin
      return '0;
    end
    if (wb.reg_write && wb.write_register == addr) begin
      return wb.write_data;
    end
    return stored;
  endfunction

  assign rs = i_if_id.instr.r.rs;
  assign rt = i_if_id.instr.r.rt;

  // Main decoder
  always_comb begin
    ctrl = '0; // Unknown opcodes fall through as nop
    case (i_if_id.instr.r.opcode)
      OP_RTYPE: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALUOP_FUNCT;
      end
      OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALUOP_ADD;
      end
      OP_LW: begin
        ctrl.alu_src    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_op     = ALUOP_ADD;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.alu_op    = ALUOP_ADD;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  // Register file, r0 never written
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (i_wb.reg_write && i_wb.write_register != 5'd0) begin
      regs[i_wb.write_register] <= i_wb.write_data;
    end
  end

  assign read_data_1 = read_reg(rs, regs[rs], i_wb);
  assign read_data_2 = read_reg(rt, regs[rt], i_wb);

  always_comb begin
    id_ex_d.ctrl              = ctrl;
    id_ex_d.read_data_1       = read_data_1;
    id_ex_d.read_data_2       = read_data_2;
    id_ex_d.sign_extended_imm = {{16{i_if_id.instr.i.imm[15]}}, i_if_id.instr.i.imm};
    id_ex_d.rt                = rt;
    id_ex_d.rd                = i_if_id.instr.r.rd;
    id_ex_d.funct             = i_if_id.instr.r.funct;
  end

  // ID/EX latch
  always_ff @(posedge clk) begin
    o_id_ex <= id_ex_d;
    if (!i_rst_n) begin
      o_id_ex.ctrl <= '0;
    end
  end

endmodule

//--- source/if_stage.sv
`timescale 1ns/1ps

module if_stage import mips_pkg::*; #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          i_rst_n,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  output if_id_t                        o_if_id
);

  localparam int AW = $clog2(IMEM_DEPTH);

  logic [31:0] imem [IMEM_DEPTH];
  logic [31:0] pc;
  logic [31:0] pc_plus_4;

  // Empty memory reads as nop
  initial begin
    for (int w = 0; w < IMEM_DEPTH; w++) begin
      imem[w] = '0;
    end
  end

  // Load port, used while the core is held in reset
  always_ff @(posedge clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_data;
    end
  end

  assign pc_plus_4 = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_plus_4; // No branches, straight-line fetch
    end
  end

  // IF/ID latch
  always_ff @(posedge clk) begin
    o_if_id.pc    <= pc_plus_4;
    o_if_id.instr <= imem[pc[AW+1:2]]; // Word index wraps with depth
    if (!i_rst_n) begin
      o_if_id.instr <= '0;
    end
  end

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mips_pkg::*; #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic    clk,
  input  logic    i_rst_n,
  input  ex_mem_t i_ex_mem,
  output wb_t     o_wb
);

  localparam int DW = $clog2(DMEM_DEPTH);

  logic [31:0]   dmem [DMEM_DEPTH];
  logic [DW-1:0] addr;
  logic [31:0]   mem_rdata;

  // MEM/WB latch contents
  logic          wb_reg_write;
  logic          wb_mem_to_reg;
  logic [4:0]    wb_write_register;
  logic [31:0]   wb_alu_result;
  logic [31:0]   wb_read_data;

  assign addr = i_ex_mem.alu_result[DW+1:2]; // Word address, wraps with depth

  // Data memory, cleared while in reset
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int w = 0; w < DMEM_DEPTH; w++) begin
        dmem[w] <= '0;
      end
    end else if (i_ex_mem.ctrl.mem_write) begin
      dmem[addr] <= i_ex_mem.write_data;
    end
  end

  assign mem_rdata = i_ex_mem.ctrl.mem_read ? dmem[addr] : '0;

  always_ff @(posedge clk) begin
    wb_alu_result     <= i_ex_mem.alu_result;
    wb_read_data      <= mem_rdata;
    wb_write_register <= i_ex_mem.write_register;
    if (!i_rst_n) begin
      wb_reg_write  <= 1'b0;
      wb_mem_to_reg <= 1'b0;
    end else begin
      wb_reg_write  <= i_ex_mem.ctrl.reg_write;
      wb_mem_to_reg <= i_ex_mem.ctrl.mem_to_reg;
    end
  end

  // Write-back mux
  always_comb begin
    o_wb.reg_write      = wb_reg_write;
    o_wb.write_register = wb_write_register;
    o_wb.write_data     = wb_mem_to_reg ? wb_read_data : wb_alu_result;
  end

endmodule

//--- source/mips.sv
`timescale 1ns/1ps

module mips import mips_pkg::*; #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          i_rst_n,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  output logic                          o_reg_write,
  output logic [4:0]                    o_write_register,
  output logic [31:0]                   o_result
);

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  wb_t     wb;     // Feeds the register file and the outputs

  if_stage #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) u_if_stage (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_imem_we   (i_imem_we),
    .i_imem_addr (i_imem_addr),
    .i_imem_data (i_imem_data),
    .o_if_id     (if_id)
  );

  id_stage u_id_stage (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_if_id (if_id),
    .i_wb    (wb),
    .o_id_ex (id_ex)
  );

  ex_stage u_ex_stage (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_id_ex  (id_ex),
    .o_ex_mem (ex_mem)
  );

  mem_stage #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_mem_stage (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_ex_mem (ex_mem),
    .o_wb     (wb)
  );

  assign o_reg_write      = wb.reg_write;
  assign o_write_register = wb.write_register;
  assign o_result         = wb.write_data;

endmodule

//--- source/mips_pkg.sv
package mips_pkg;

  // Primary opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // R-type function codes
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  // alu_op from the decoder
  localparam logic [1:0] ALUOP_ADD   = 2'b00; // Address calc and addi
  localparam logic [1:0] ALUOP_FUNCT = 2'b10; // Operation taken from funct

  // Operation actually performed by the ALU
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_ctl_e;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  // One instruction word, R and I views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  typedef struct packed {
    logic       alu_src;    // Second operand is the immediate
    logic [1:0] alu_op;
    logic       reg_dst;    // Destination is rd, else rt
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] pc;
    instr_u      instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] read_data_1;
    logic [31:0] read_data_2;
    logic [31:0] sign_extended_imm;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [5:0]  funct;
  } id_ex_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] alu_result;
    logic [31:0] write_data;     // Store data for sw
    logic [4:0]  write_register;
  } ex_mem_t;

  // Write-back bus back to the register file
  typedef struct packed {
    logic        reg_write;
    logic [4:0]  write_register;
    logic [31:0] write_data;
  } wb_t;

endpackage

//--- verification/mips_asserts.sv
`timescale 1ns/1ps

module mips_asserts (
  input logic        clk,
  input logic        i_rst_n,
  input logic        i_reg_write,
  input logic [4:0]  i_write_register,
  input logic [31:0] i_result
);

  // The MEM/WB latch clears on the reset edge
  property reg_write_low_after_reset;
    @(posedge clk) !i_rst_n |=> !i_reg_write;
  endproperty

  property dest_nonzero;
    @(posedge clk) disable iff (!i_rst_n) i_reg_write |-> i_write_register != 5'd0;
  endproperty

  property result_known;
    @(posedge clk) disable iff (!i_rst_n) i_reg_write |-> !$isunknown(i_result);
  endproperty

  a_reg_write_low:  assert property (reg_write_low_after_reset) else $error("write strobe after reset");
  a_dest_nonzero:   assert property (dest_nonzero) else $error("write-back to register 0");
  a_result_known:   assert property (result_known) else $error("unknown write-back data");

endmodule

bind mips mips_asserts u_mips_asserts (
  .clk              (clk),
  .i_rst_n          (i_rst_n),
  .i_reg_write      (o_reg_write),
  .i_write_register (o_write_register),
  .i_result         (o_result)
);

//--- verification/mips_checker.sv
`timescale 1ns/1ps

module mips_checker import mips_pkg::*; #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          i_rst_n,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  input  logic                          i_reg_write,
  input  logic [4:0]                    i_write_register,
  input  logic [31:0]                   i_result,
  input  int                            i_test_idx,
  input  logic                          i_test_end,
  output int                            o_mismatches,
  output int                            o_missing,
  output int                            o_extra
);

  typedef struct packed {
    int          cycle;  // Edges after reset release
    logic [4:0]  dest;
    logic [31:0] data;
  } wb_event_t;

  logic [31:0] loaded [IMEM_DEPTH];
  wb_event_t   expected [$];
  int          edge_cnt;
  logic        in_reset;

  initial begin
    o_mismatches = 0;
    o_missing    = 0;
    o_extra      = 0;
    edge_cnt     = 0;
    in_reset     = 1'b1;
  end

  function automatic string test_name(input int idx);
    case (idx)
      0:       return "alu_rr";
      1:       return "alu_imm";
      2:       return "mem";
      3:       return "timing";
      default: return "random";
    endcase
  endfunction

  // In-order ISA model over the loaded program
  function automatic void run_model();
    logic [31:0] regs [32];
    logic [31:0] dmem [DMEM_DEPTH];
    instr_u      w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] ea;
    logic [31:0] res;
    logic [4:0]  dst;
    logic        wr;
    wb_event_t   ev;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    for (int m = 0; m < DMEM_DEPTH; m++) dmem[m] = '0;
    expected.delete();
    for (int n = 0; n < IMEM_DEPTH; n++) begin
      w    = loaded[n];
      a    = regs[w.i.rs];
      b    = regs[w.i.rt];
      sext = {{16{w.i.imm[15]}}, w.i.imm};
      ea   = a + sext;
      dst  = w.i.rt;
      res  = '0;
      wr   = 1'b0;
      case (w.r.opcode)
        OP_RTYPE: begin
          dst = w.r.rd;
          wr  = 1'b1;
          case (w.r.funct)
            FN_ADD:  res = a + b;
            FN_SUB:  res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: wr = 1'b0;
          endcase
        end
        OP_ADDI: begin
          wr  = 1'b1;
          res = ea;
        end
        OP_LW: begin
          wr  = 1'b1;
          res = dmem[ea[31:2] % DMEM_DEPTH];
        end
        OP_SW:   dmem[ea[31:2] % DMEM_DEPTH] = b;
        default: wr = 1'b0;
      endcase
      if (wr && dst != 5'd0) begin
        regs[dst] = res;
        ev.cycle  = n + 4;  // Visible after edge n+4
        ev.dest   = dst;
        ev.data   = res;
        expected.push_back(ev);
      end
    end
  endfunction

  // Sampled mid-cycle so all DUT outputs are settled
  always @(negedge clk) begin
    wb_event_t ev;
    if (i_imem_we) loaded[i_imem_addr] = i_imem_data;
    if (!i_rst_n) begin
      in_reset = 1'b1;
      edge_cnt = 0;
    end else begin
      if (in_reset) begin
        run_model();
        in_reset = 1'b0;
      end else begin
        edge_cnt++;
      end
      if (i_reg_write) begin
        if (expected.size() == 0) begin
          $display("Extra write-back in test %s: register %0d data %h at cycle %0d",
                   test_name(i_test_idx), i_write_register, i_result, edge_cnt);
          o_extra++;
        end else begin
          ev = expected.pop_front();
          if (ev.cycle != edge_cnt) begin
            $display("Fail %s cycle: expected %0d actual %0d",
                     test_name(i_test_idx), ev.cycle, edge_cnt);
            o_mismatches++;
          end
          if (ev.dest != i_write_register) begin
            $display("Fail %s register: expected %0d actual %0d",
                     test_name(i_test_idx), ev.dest, i_write_register);
            o_mismatches++;
          end
          if (ev.data != i_result) begin
            $display("Fail %s data: expected %h actual %h",
                     test_name(i_test_idx), ev.data, i_result);
            o_mismatches++;
          end
        end
      end
      if (i_test_end) begin
        while (expected.size() > 0) begin
          ev = expected.pop_front();
          $display("Missing write-back in test %s: register %0d was never written",
                   test_name(i_test_idx), ev.dest);
          o_missing++;
        end
      end
    end
  end

endmodule

//--- verification/mips_tb.sv
`timescale 1ns/1ps

module mips_tb import mips_pkg::*; ();

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;
  localparam int AW         = $clog2(IMEM_DEPTH);
  localparam int NUM_TESTS  = 5;

  logic          clk = 1'b0;
  logic          rst_n = 1'b0;
  logic          imem_we = 1'b0;
  logic [AW-1:0] imem_addr = '0;
  logic [31:0]   imem_data = '0;
  logic          reg_write;
  logic [4:0]    write_register;
  logic [31:0]   result;
  int            test_idx = 0;
  logic          test_end = 1'b0;
  int            mismatches;
  int            missing;
  int            extra;

  logic [31:0] progs [NUM_TESTS][IMEM_DEPTH];
  int          lens [NUM_TESTS];
  logic [31:0] seed = 32'h7e01;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  always #2 clk = ~clk;

  mips #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) i_dut (
    .clk (clk), .i_rst_n (rst_n),
    .i_imem_we (imem_we), .i_imem_addr (imem_addr), .i_imem_data (imem_data),
    .o_reg_write (reg_write), .o_write_register (write_register), .o_result (result)
  );

  mips_checker #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_checker (
    .clk (clk), .i_rst_n (rst_n),
    .i_imem_we (imem_we), .i_imem_addr (imem_addr), .i_imem_data (imem_data),
    .i_reg_write (reg_write), .i_write_register (write_register), .i_result (result),
    .i_test_idx (test_idx), .i_test_end (test_end),
    .o_mismatches (mismatches), .o_missing (missing), .o_extra (extra)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rd, rs, rt);
    instr_u w;
    w          = '0;
    w.r.opcode = OP_RTYPE;
    w.r.rs     = 5'(rs);
    w.r.rt     = 5'(rt);
    w.r.rd     = 5'(rd);
    w.r.funct  = fn;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, rs,
                                        input logic [15:0] imm);
    instr_u w;
    w          = '0;
    w.i.opcode = op;
    w.i.rs     = 5'(rs);
    w.i.rt     = 5'(rt);
    w.i.imm    = imm;
    return w;
  endfunction

  task automatic put(input int t, input logic [31:0] w);
    progs[t][lens[t]] = w;
    lens[t]++;
  endtask

  task automatic build_random(input int t);
    int          last_wr [8];
    int          src [2];
    int          kind;
    int          r;
    logic [15:0] imm;
    for (int k = 0; k < 8; k++) last_wr[k] = -10;
    for (int i = 0; i < 30; i++) begin
      seed = lcg_next(seed);
      kind = int'(seed[31:29]);
      imm  = seed[15:0];
      for (int s = 0; s < 2; s++) begin
        src[s] = 0;
        for (int tries = 0; tries < 8; tries++) begin
          seed = lcg_next(seed);
          r    = int'(seed[30:28]);
          if (i - last_wr[r] >= 3) begin
            src[s] = r;
            break;
          end
        end
      end
      seed = lcg_next(seed);
      r    = int'(seed[30:28]);  // Destination may be r0
      case (kind)
        0: put(t, enc_r(FN_ADD, r, src[0], src[1]));
        1: put(t, enc_r(FN_SUB, r, src[0], src[1]));
        2: put(t, enc_r(FN_AND, r, src[0], src[1]));
        3: put(t, enc_r(FN_OR,  r, src[0], src[1]));
        4: put(t, enc_r(FN_SLT, r, src[0], src[1]));
        5: put(t, enc_i(OP_ADDI, r, src[0], imm));
        6: put(t, enc_i(OP_LW, r, src[0], {8'h0, imm[7:0]}));
        default: put(t, enc_i(OP_SW, src[1], src[0], {8'h0, imm[7:0]}));
      endcase
      if (kind != 7) last_wr[r] = i;
    end
  endtask

  task automatic build_all();
    for (int t = 0; t < NUM_TESTS; t++) begin
      lens[t] = 0;
      for (int w = 0; w < IMEM_DEPTH; w++) progs[t][w] = '0;
    end
    // Seed r1..r3 and pad with two nops before the R-type ops
    seed = lcg_next(seed);
    put(0, enc_i(OP_ADDI, 1, 0, seed[15:0]));
    seed = lcg_next(seed);
    put(0, enc_i(OP_ADDI, 2, 0, seed[31:16]));
    put(0, enc_i(OP_ADDI, 3, 0, 16'hfffb));
    put(0, 32'h0);
    put(0, 32'h0);
    put(0, enc_r(FN_ADD, 4, 1, 2));
    put(0, enc_r(FN_SUB, 5, 3, 1));
    put(0, enc_r(FN_AND, 6, 1, 3));
    put(0, enc_r(FN_OR,  7, 2, 3));
    put(0, enc_r(FN_SLT, 8, 3, 2));
    put(0, enc_r(FN_SLT, 9, 2, 3));
    // alu_imm
    put(1, enc_i(OP_ADDI, 5, 0, 16'hffff));
    put(1, enc_i(OP_ADDI, 0, 0, 16'h0007));  // Write to r0 gives no event
    put(1, enc_i(OP_ADDI, 6, 0, 16'h8000));
    put(1, 32'h0);
    put(1, enc_i(OP_ADDI, 7, 5, 16'hfffd));
    put(1, enc_r(FN_ADD, 8, 0, 6));
    put(1, enc_r(FN_OR,  9, 0, 0));
    // Store address DMEM_DEPTH*4+8 wraps to word 2
    put(2, enc_i(OP_ADDI, 1, 0, 16'h1234));
    put(2, enc_i(OP_ADDI, 2, 0, 16'(DMEM_DEPTH * 4 + 8)));
    put(2, 32'h0);
    put(2, 32'h0);
    put(2, enc_i(OP_SW, 1, 2, 16'h0000));
    put(2, enc_i(OP_LW, 3, 0, 16'h0008));
    put(2, enc_i(OP_LW, 4, 0, 16'h000c));
    put(2, enc_i(OP_LW, 5, 2, 16'hfffc));
    // Back to back writers for the timing test
    for (int k = 1; k <= 4; k++) put(3, enc_i(OP_ADDI, k, 0, 16'(k * 3)));
    build_random(4);
  endtask

  task automatic run_test(input int t);
    @(posedge clk);
    rst_n    <= 1'b0;
    test_idx <= t;
    for (int w = 0; w < IMEM_DEPTH; w++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= AW'(w);
      imem_data <= progs[t][w];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (lens[t] + 4) @(posedge clk);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    build_all();
    for (int t = 0; t < NUM_TESTS; t++) cycle_limit += 16 + IMEM_DEPTH + lens[t] + 8;
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    repeat (2) @(posedge clk);
    $display("Errors: mismatches %0d, missing %0d, extra %0d", mismatches, missing, extra);
    if (mismatches + missing + extra == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
source/mips_pkg.sv
source/if_stage.sv
source/id_stage.sv
source/ex_stage.sv
source/mem_stage.sv
source/mips.sv
verification/mips_asserts.sv
verification/mips_checker.sv
verification/mips_tb.sv
